/* logic/agc_word_pkg.sv */
`default_nettype none

// Machine word and register file definitions
package agc_word_pkg;

  // 15-bit one's-complement word
  localparam int word_w = 15;

  typedef logic [word_w-1:0] word_t;

  // Register file targets
  // Encoding order matters to nothing outside the register file
  typedef enum logic [3:0] {
    A,
    L,
    Q,
    EB,
    FB,
    BB,
    ZERO,
    CYR,
    SR,
    CYL,
    SL,
    TIME1,
    TIME2
  } reg_sel_t;

  // Bank register layout within a word
  typedef struct packed {
    logic [2:0] fb;
    logic [2:0] eb;
    logic [8:0] low;
  } bank_fields_t;

  // Same word seen as data or as its bank fields
  typedef union packed {
    word_t        data;
    bank_fields_t fields;
  } bank_word_u;

endpackage

`default_nettype wire

/* logic/agc_mem_pkg.sv */
`default_nettype none

// Memory map definitions for ROM and RAM banking
package agc_mem_pkg;

  localparam int soft_addr_w = 12;
  localparam int rom_addr_w  = 14;
  localparam int ram_addr_w  = 11;
  localparam int bank_w      = 3;

  typedef logic [soft_addr_w-1:0] soft_addr_t;
  typedef logic [rom_addr_w-1:0]  rom_addr_t;
  typedef logic [ram_addr_w-1:0]  ram_addr_t;
  typedef logic [bank_w-1:0]      bank_sel_t;

  // Lowest fixed ROM software address
  localparam soft_addr_t rom_fixed_base = 12'o4000;

  // Lowest ROM software address
  // Also one ROM bank, and the idle ROM address on RAM reads
  localparam soft_addr_t rom_window_base = 12'o2000;

  // First banked RAM software address
  localparam soft_addr_t ram_fixed_limit = 12'o1400;

  // One RAM bank
  localparam ram_addr_t ram_bank_size = 11'o0400;

  // Added instead of the bank table when EB bit 2 is set
  localparam ram_addr_t ram_high_offset = 11'o2000;

endpackage

`default_nettype wire

/* logic/agc_reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

// Central and special registers, two write and two read ports
module agc_reg_file (
  input  wire logic                   clk,
  input  wire logic                   rst_l,
  input  wire logic                   wr1_en,
  input  wire logic                   wr2_en,
  input  wire agc_word_pkg::reg_sel_t wr1_sel,
  input  wire agc_word_pkg::reg_sel_t wr2_sel,
  input  wire agc_word_pkg::reg_sel_t rs1_sel,
  input  wire agc_word_pkg::reg_sel_t rs2_sel,
  input  wire agc_word_pkg::word_t    wr1_data,
  input  wire agc_word_pkg::word_t    wr2_data,
  output agc_word_pkg::word_t         rs1_data,
  output agc_word_pkg::word_t         rs2_data,
  output agc_mem_pkg::bank_sel_t      bank_eb,
  output agc_mem_pkg::bank_sel_t      bank_fb
);

  import agc_word_pkg::*;
  import agc_mem_pkg::*;

  // Plain registers indexed by select code
  // Slots for EB, FB, BB and ZERO are never written
  word_t gpr_q [0:15];

  // Bank bits, shared by EB, FB and BB
  bank_sel_t eb_q;
  bank_sel_t fb_q;

  // Write data after the editing transform
  word_t wr1_edit;
  word_t wr2_edit;

  // Write data split into bank fields
  bank_word_u wr1_bank;
  bank_word_u wr2_bank;

  // Stored bank registers as read back
  bank_word_u eb_view;
  bank_word_u fb_view;
  bank_word_u bb_view;

  // Stored value per select code
  word_t view [0:15];

  // Targets held in gpr_q
  function automatic logic is_gpr(input reg_sel_t sel);
    case (sel)
      EB, FB, BB, ZERO: is_gpr = 1'b0;
      default:          is_gpr = 1'b1;
    endcase
  endfunction

  // Targets that carry EB bits
  function automatic logic has_eb(input reg_sel_t sel);
    has_eb = (sel == EB) || (sel == BB);
  endfunction

  // Targets that carry FB bits
  function automatic logic has_fb(input reg_sel_t sel);
    has_fb = (sel == FB) || (sel == BB);
  endfunction

  // Editing registers shift or rotate on the way in
  function automatic word_t edit_word(input reg_sel_t sel, input word_t d);
    case (sel)
      // Rotate right
      CYR:     edit_word = {d[0], d[word_w-1:1]};
      // Shift right, sign kept
      SR:      edit_word = {d[word_w-1], d[word_w-1:1]};
      // Rotate left
      CYL:     edit_word = {d[word_w-2:0], d[word_w-1]};
      // Shift left, zero fill
      SL:      edit_word = {d[word_w-2:0], 1'b0};
      default: edit_word = d;
    endcase
  endfunction

  assign wr1_edit = edit_word(wr1_sel, wr1_data);
  assign wr2_edit = edit_word(wr2_sel, wr2_data);

  assign wr1_bank.data = wr1_data;
  assign wr2_bank.data = wr2_data;

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      for (int i = 0; i < 16; i++) begin
        gpr_q[i] <= '0;
      end
      eb_q <= '0;
      fb_q <= '0;
    end else begin
      // Port 1 first, so port 2 wins on a shared target
      if (wr1_en && is_gpr(wr1_sel)) begin
        gpr_q[wr1_sel] <= wr1_edit;
      end
      if (wr2_en && is_gpr(wr2_sel)) begin
        gpr_q[wr2_sel] <= wr2_edit;
      end
      // Bank writes touch only their own fields
      if (wr1_en && has_eb(wr1_sel)) begin
        eb_q <= wr1_bank.fields.eb;
      end
      if (wr2_en && has_eb(wr2_sel)) begin
        eb_q <= wr2_bank.fields.eb;
      end
      if (wr1_en && has_fb(wr1_sel)) begin
        fb_q <= wr1_bank.fields.fb;
      end
      if (wr2_en && has_fb(wr2_sel)) begin
        fb_q <= wr2_bank.fields.fb;
      end
    end
  end

  always_comb begin
    // Bank reads masked to their fields
    eb_view.fields = '{fb: '0, eb: eb_q, low: '0};
    fb_view.fields = '{fb: fb_q, eb: '0, low: '0};
    bb_view.fields = '{fb: fb_q, eb: eb_q, low: '0};

    for (int i = 0; i < 16; i++) begin
      view[i] = gpr_q[i];
    end
    view[EB]   = eb_view.data;
    view[FB]   = fb_view.data;
    view[BB]   = bb_view.data;
    view[ZERO] = '0;
  end

  // Forwarding order: port 2, then port 1, then storage
  // Forwarded data is raw, before any editing transform
  assign rs1_data = (wr2_en && wr2_sel == rs1_sel) ? wr2_data :
                    (wr1_en && wr1_sel == rs1_sel) ? wr1_data : view[rs1_sel];

  assign rs2_data = (wr2_en && wr2_sel == rs2_sel) ? wr2_data :
                    (wr1_en && wr1_sel == rs2_sel) ? wr1_data : view[rs2_sel];

  // Translator sees stored bank bits only
  assign bank_eb = eb_q;
  assign bank_fb = fb_q;

endmodule

`default_nettype wire

/* logic/rom_bank_translate.sv */
`timescale 1ns/10ps
`default_nettype none

// Software address to physical ROM address
module rom_bank_translate (
  input  wire agc_mem_pkg::soft_addr_t soft_addr,
  input  wire agc_mem_pkg::bank_sel_t  bank,
  output agc_mem_pkg::rom_addr_t       rom_addr
);

  import agc_mem_pkg::*;

  logic       is_fixed;
  soft_addr_t fixed_addr;
  rom_addr_t  bank_offset;
  rom_addr_t  banked_addr;

  // Fixed ROM sits at the top of the software space
  assign is_fixed   = soft_addr >= rom_fixed_base;
  assign fixed_addr = soft_addr - rom_fixed_base;

  // Bank number times one bank, by table
  always_comb begin
    case (bank)
      3'd0:    bank_offset = 14'o00000;
      3'd1:    bank_offset = 14'o02000;
      3'd2:    bank_offset = 14'o04000;
      3'd3:    bank_offset = 14'o06000;
      3'd4:    bank_offset = 14'o10000;
      3'd5:    bank_offset = 14'o12000;
      3'd6:    bank_offset = 14'o14000;
      default: bank_offset = 14'o16000;
    endcase
  end

  // Banked window lands above the fixed image
  assign banked_addr = rom_addr_t'(soft_addr) + rom_addr_t'(rom_window_base) + bank_offset;

  assign rom_addr = is_fixed ? rom_addr_t'(fixed_addr) : banked_addr;

endmodule

`default_nettype wire

/* logic/ram_bank_translate.sv */
`timescale 1ns/10ps
`default_nettype none

// Software address to physical RAM address
module ram_bank_translate (
  input  wire agc_mem_pkg::soft_addr_t soft_addr,
  input  wire agc_mem_pkg::bank_sel_t  bank,
  output agc_mem_pkg::ram_addr_t       ram_addr
);

  import agc_mem_pkg::*;

  logic      is_fixed;
  ram_addr_t low_addr;
  ram_addr_t table_offset;
  ram_addr_t bank_offset;

  // Fixed RAM below the banked window
  assign is_fixed = soft_addr < ram_fixed_limit;
  assign low_addr = soft_addr[ram_addr_w-1:0];

  // Low two bank bits pick a bank, no multiplier
  always_comb begin
    case (bank[1:0])
      2'd0:    table_offset = '0;
      2'd1:    table_offset = ram_bank_size;
      2'd2:    table_offset = ram_bank_size << 1;
      default: table_offset = (ram_bank_size << 1) + ram_bank_size;
    endcase
  end

  // Bit 2 overrides the table
  assign bank_offset = bank[2] ? ram_high_offset : table_offset;

  // Sum wraps at 11 bits
  assign ram_addr = is_fixed ? low_addr : low_addr + bank_offset;

endmodule

`default_nettype wire

/* logic/addr_translate.sv */
`timescale 1ns/10ps
`default_nettype none

// Program counter, read and write address translation
module addr_translate (
  input  wire agc_mem_pkg::soft_addr_t addr_pc,
  input  wire agc_mem_pkg::soft_addr_t addr_r,
  input  wire agc_mem_pkg::soft_addr_t addr_w,
  input  wire agc_mem_pkg::bank_sel_t  bank_eb,
  input  wire agc_mem_pkg::bank_sel_t  bank_fb,
  input  wire logic                    write_req,
  output agc_mem_pkg::rom_addr_t       addr_rom_pc,
  output agc_mem_pkg::rom_addr_t       addr_rom_r,
  output agc_mem_pkg::ram_addr_t       addr_ram_r,
  output agc_mem_pkg::ram_addr_t       addr_ram_w,
  output logic                         ram_write_en
);

  import agc_mem_pkg::*;

  rom_addr_t rom_r_raw;
  ram_addr_t ram_r_raw;
  logic      read_is_rom;
  logic      write_is_ram;

  // Instruction fetch always from ROM
  rom_bank_translate u_rom_pc (
    .soft_addr (addr_pc),
    .bank      (bank_fb),
    .rom_addr  (addr_rom_pc)
  );

  // Both read views computed, region picks one
  rom_bank_translate u_rom_r (
    .soft_addr (addr_r),
    .bank      (bank_fb),
    .rom_addr  (rom_r_raw)
  );

  ram_bank_translate u_ram_r (
    .soft_addr (addr_r),
    .bank      (bank_eb),
    .ram_addr  (ram_r_raw)
  );

  ram_bank_translate u_ram_w (
    .soft_addr (addr_w),
    .bank      (bank_eb),
    .ram_addr  (addr_ram_w)
  );

  assign read_is_rom  = addr_r >= rom_window_base;
  assign write_is_ram = addr_w < rom_window_base;

  // Unused region parked at its lowest address
  assign addr_rom_r = read_is_rom ? rom_r_raw : rom_addr_t'(rom_window_base);
  assign addr_ram_r = read_is_rom ? '0 : ram_r_raw;

  // ROM is read only
  assign ram_write_en = write_is_ram ? write_req : 1'b0;

endmodule

`default_nettype wire

/* logic/agc_mem_unit.sv */
`timescale 1ns/10ps
`default_nettype none

// Register file and memory banking front end
module agc_mem_unit (
  input  wire logic                    clk,
  input  wire logic                    rst_l,
  input  wire logic                    wr1_en,
  input  wire logic                    wr2_en,
  input  wire agc_word_pkg::reg_sel_t  wr1_sel,
  input  wire agc_word_pkg::reg_sel_t  wr2_sel,
  input  wire agc_word_pkg::reg_sel_t  rs1_sel,
  input  wire agc_word_pkg::reg_sel_t  rs2_sel,
  input  wire agc_word_pkg::word_t     wr1_data,
  input  wire agc_word_pkg::word_t     wr2_data,
  output agc_word_pkg::word_t          rs1_data,
  output agc_word_pkg::word_t          rs2_data,
  input  wire agc_mem_pkg::soft_addr_t addr_pc,
  input  wire agc_mem_pkg::soft_addr_t addr_r,
  input  wire agc_mem_pkg::soft_addr_t addr_w,
  input  wire logic                    write_req,
  output agc_mem_pkg::rom_addr_t       addr_rom_pc,
  output agc_mem_pkg::rom_addr_t       addr_rom_r,
  output agc_mem_pkg::ram_addr_t       addr_ram_r,
  output agc_mem_pkg::ram_addr_t       addr_ram_w,
  output logic                         ram_write_en
);

  import agc_mem_pkg::*;

  // Stored bank bits, one cycle behind a bank write
  bank_sel_t bank_eb;
  bank_sel_t bank_fb;

  agc_reg_file u_reg_file (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr1_en   (wr1_en),
    .wr2_en   (wr2_en),
    .wr1_sel  (wr1_sel),
    .wr2_sel  (wr2_sel),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .wr1_data (wr1_data),
    .wr2_data (wr2_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .bank_eb  (bank_eb),
    .bank_fb  (bank_fb)
  );

  // Purely combinational, no clock needed
  addr_translate u_addr_translate (
    .addr_pc      (addr_pc),
    .addr_r       (addr_r),
    .addr_w       (addr_w),
    .bank_eb      (bank_eb),
    .bank_fb      (bank_fb),
    .write_req    (write_req),
    .addr_rom_pc  (addr_rom_pc),
    .addr_rom_r   (addr_rom_r),
    .addr_ram_r   (addr_ram_r),
    .addr_ram_w   (addr_ram_w),
    .ram_write_en (ram_write_en)
  );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// Free-running 4 ns testbench clock
module tb_clock_gen (
  output logic clk
);

  // Starts low, first rising edge at 2 ns
  initial begin
    clk = 1'b0;
  end

  always begin
    #2 clk = ~clk;
  end

endmodule

`default_nettype wire

/* tb/agc_mem_unit_checker.sv */
`timescale 1ns/10ps
`default_nettype none

// Port-level properties of the memory unit
module agc_mem_unit_checker (
  input wire logic                    clk,
  input wire logic                    rst_l,
  input wire logic                    wr1_en,
  input wire logic                    wr2_en,
  input wire agc_word_pkg::reg_sel_t  wr1_sel,
  input wire agc_word_pkg::reg_sel_t  wr2_sel,
  input wire agc_word_pkg::reg_sel_t  rs1_sel,
  input wire agc_word_pkg::word_t     rs1_data,
  input wire agc_mem_pkg::soft_addr_t addr_r,
  input wire agc_mem_pkg::soft_addr_t addr_w,
  input wire agc_mem_pkg::ram_addr_t  addr_ram_r,
  input wire logic                    ram_write_en
);

  import agc_word_pkg::*;
  import agc_mem_pkg::*;

  // Read by the testbench at the end of the run
  int fail_count = 0;

  // ROM is never written
  rom_write_blocked: assert property (@(posedge clk) disable iff (!rst_l)
    (addr_w >= rom_window_base) |-> !ram_write_en)
    else begin
      fail_count++;
      $error("RAM write enable high for ROM address %o", addr_w);
    end

  // RAM side parked at zero on a ROM read
  ram_read_idle: assert property (@(posedge clk) disable iff (!rst_l)
    (addr_r >= rom_window_base) |-> (addr_ram_r == '0))
    else begin
      fail_count++;
      $error("RAM read address %o not idle for ROM read", addr_ram_r);
    end

  // ZERO reads as zero unless a write forwards onto it
  zero_reads_zero: assert property (@(posedge clk) disable iff (!rst_l)
    (rs1_sel == ZERO && !(wr1_en && wr1_sel == ZERO) && !(wr2_en && wr2_sel == ZERO))
      |-> (rs1_data == '0))
    else begin
      fail_count++;
      $error("ZERO read returned %o", rs1_data);
    end

endmodule

bind agc_mem_unit agc_mem_unit_checker chk (.*);

`default_nettype wire

/* tb/agc_mem_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

// Table-driven testbench for the register file and banking front end
module agc_mem_unit_tb;

  import agc_word_pkg::*;
  import agc_mem_pkg::*;

  localparam int reset_cycles = 8;
  localparam int n_random     = 64;
  localparam int clk_period   = 4;

  // One row per clock cycle
  typedef struct packed {
    logic       w1_en;
    reg_sel_t   w1_sel;
    word_t      w1_data;
    logic       w2_en;
    reg_sel_t   w2_sel;
    word_t      w2_data;
    reg_sel_t   r1_sel;
    reg_sel_t   r2_sel;
    soft_addr_t pc;
    soft_addr_t rd;
    soft_addr_t wr;
    logic       wreq;
    word_t      exp1;
    word_t      exp2;
  } step_t;

  logic       clk;
  logic       rst_l;
  logic       wr1_en;
  logic       wr2_en;
  reg_sel_t   wr1_sel;
  reg_sel_t   wr2_sel;
  reg_sel_t   rs1_sel;
  reg_sel_t   rs2_sel;
  word_t      wr1_data;
  word_t      wr2_data;
  word_t      rs1_data;
  word_t      rs2_data;
  soft_addr_t addr_pc;
  soft_addr_t addr_r;
  soft_addr_t addr_w;
  logic       write_req;
  rom_addr_t  addr_rom_pc;
  rom_addr_t  addr_rom_r;
  ram_addr_t  addr_ram_r;
  ram_addr_t  addr_ram_w;
  logic       ram_write_en;

  step_t       steps[$];
  string       names[$];
  int          fixed_len;
  logic        table_ready = 1'b0;
  logic [31:0] seed = 32'h76a57224;

  // Expected stored bank bits
  bank_sel_t model_eb;
  bank_sel_t model_fb;

  tb_clock_gen clock (.clk(clk));

  agc_mem_unit uut (.*);

  // Fixed ROM maps to the bottom, banked windows above it
  function automatic rom_addr_t rom_map(input soft_addr_t s, input bank_sel_t f);
    if (s >= 12'o4000) begin
      return rom_addr_t'(s - 12'o4000);
    end else begin
      return rom_addr_t'(s) + 14'o2000 + rom_addr_t'(f) * 14'o2000;
    end
  endfunction

  function automatic ram_addr_t ram_map(input soft_addr_t s, input bank_sel_t e);
    ram_addr_t off;
    if (s < 12'o1400) begin
      return s[10:0];
    end
    // EB bit 2 jumps to the upper half
    off = e[2] ? 11'o2000 : ram_addr_t'(e[1:0]) * 11'o400;
    return s[10:0] + off;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_step(input string name,
                          input logic e1, input reg_sel_t s1, input word_t d1,
                          input logic e2, input reg_sel_t s2, input word_t d2,
                          input reg_sel_t r1, input reg_sel_t r2,
                          input soft_addr_t pc, input soft_addr_t rd,
                          input soft_addr_t wr, input logic wreq,
                          input word_t x1, input word_t x2);
    steps.push_back('{e1, s1, d1, e2, s2, d2, r1, r2, pc, rd, wr, wreq, x1, x2});
    names.push_back(name);
  endtask

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0o actual %0o", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  // Drive on the falling edge, check before the next rising edge
  task automatic run_step(input int i);
    step_t     st;
    rom_addr_t rom_r;
    ram_addr_t ram_r;
    logic      wen;
    st = steps[i];
    @(negedge clk);
    wr1_en    = st.w1_en;
    wr1_sel   = st.w1_sel;
    wr1_data  = st.w1_data;
    wr2_en    = st.w2_en;
    wr2_sel   = st.w2_sel;
    wr2_data  = st.w2_data;
    rs1_sel   = st.r1_sel;
    rs2_sel   = st.r2_sel;
    addr_pc   = st.pc;
    addr_r    = st.rd;
    addr_w    = st.wr;
    write_req = st.wreq;
    #1.5;
    // Region of the read decides which side is live
    if (st.rd >= 12'o2000) begin
      rom_r = rom_map(st.rd, model_fb);
      ram_r = '0;
    end else begin
      rom_r = 14'o2000;
      ram_r = ram_map(st.rd, model_eb);
    end
    wen = (st.wr < 12'o2000) ? st.wreq : 1'b0;
    expect_equal({names[i], " rs1_data"}, st.exp1, rs1_data);
    expect_equal({names[i], " rs2_data"}, st.exp2, rs2_data);
    expect_equal({names[i], " addr_rom_pc"}, rom_map(st.pc, model_fb), addr_rom_pc);
    expect_equal({names[i], " addr_rom_r"}, rom_r, addr_rom_r);
    expect_equal({names[i], " addr_ram_r"}, ram_r, addr_ram_r);
    expect_equal({names[i], " addr_ram_w"}, ram_map(st.wr, model_eb), addr_ram_w);
    expect_equal({names[i], " ram_write_en"}, wen, ram_write_en);
    // Bank bits move at the coming rising edge, port 2 last
    if (st.w1_en && (st.w1_sel == EB || st.w1_sel == BB)) begin
      model_eb = st.w1_data[11:9];
    end
    if (st.w1_en && (st.w1_sel == FB || st.w1_sel == BB)) begin
      model_fb = st.w1_data[14:12];
    end
    if (st.w2_en && (st.w2_sel == EB || st.w2_sel == BB)) begin
      model_eb = st.w2_data[11:9];
    end
    if (st.w2_en && (st.w2_sel == FB || st.w2_sel == BB)) begin
      model_fb = st.w2_data[14:12];
    end
  endtask

  initial begin
    word_t      bank_word;
    word_t      rnd_data;
    soft_addr_t rnd_pc;
    soft_addr_t rnd_rd;
    soft_addr_t rnd_wr;
    rst_l     = 1'b0;
    wr1_en    = 1'b0;
    wr2_en    = 1'b0;
    wr1_sel   = A;
    wr2_sel   = A;
    rs1_sel   = A;
    rs2_sel   = A;
    wr1_data  = '0;
    wr2_data  = '0;
    addr_pc   = '0;
    addr_r    = '0;
    addr_w    = '0;
    write_req = 1'b0;
    model_eb  = '0;
    model_fb  = '0;

    // Plain registers, forwarding and double writes
    add_step("wr_a", 1, A, 15'o12345, 0, A, '0, A, L,
             12'o2345, 12'o1500, 12'o0100, 1, 15'o12345, '0);
    add_step("rd_a", 0, A, '0, 0, A, '0, A, Q,
             12'o4567, 12'o3000, 12'o2100, 1, 15'o12345, '0);
    add_step("dbl_q", 1, Q, 15'o11111, 1, Q, 15'o22222, Q, Q,
             12'o0000, 12'o5000, 12'o1377, 0, 15'o22222, 15'o22222);
    add_step("fwd_port1", 1, L, 15'o33333, 1, TIME1, 15'o44444, L, TIME1,
             12'o7777, 12'o0000, 12'o1400, 1, 15'o33333, 15'o44444);
    add_step("wr_time2", 1, TIME2, 15'o55555, 0, A, '0, Q, TIME2,
             12'o3777, 12'o1777, 12'o0777, 1, 15'o22222, 15'o55555);
    add_step("rd_timers", 0, A, '0, 0, A, '0, TIME1, TIME2,
             12'o4000, 12'o2000, 12'o2000, 1, 15'o44444, 15'o55555);
    add_step("rd_l", 0, A, '0, 0, A, '0, L, A,
             12'o2000, 12'o1377, 12'o1777, 1, 15'o33333, 15'o12345);
    // Editing registers, raw on forward, transformed in storage
    add_step("wr_cyr_sr", 1, CYR, 15'h0003, 1, SR, 15'h4002, CYR, SR,
             12'o1234, 12'o6543, 12'o0001, 1, 15'h0003, 15'h4002);
    add_step("wr_cyl_sl", 1, CYL, 15'h4001, 1, SL, 15'h4001, CYR, SR,
             12'o2222, 12'o0666, 12'o3333, 1, 15'h4001, 15'h6001);
    add_step("rd_cyl_sl", 0, A, '0, 0, A, '0, CYL, SL,
             12'o4444, 12'o1111, 12'o1001, 0, 15'h0003, 15'h0002);
    // Bank registers touch and show only their fields
    add_step("wr_eb", 1, EB, 15'h7fff, 0, A, '0, EB, FB,
             12'o2777, 12'o1600, 12'o1600, 1, 15'h7fff, '0);
    add_step("wr_fb", 0, A, '0, 1, FB, 15'h5a00, EB, BB,
             12'o3456, 12'o1700, 12'o1500, 1, 15'h0e00, 15'h0e00);
    add_step("rd_fb", 0, A, '0, 0, A, '0, FB, BB,
             12'o2100, 12'o3100, 12'o1450, 1, 15'h5000, 15'h5e00);
    add_step("wr_bb", 1, BB, 15'h21ff, 0, A, '0, BB, ZERO,
             12'o2654, 12'o1432, 12'o1432, 1, 15'h21ff, '0);
    add_step("rd_bb", 0, A, '0, 0, A, '0, BB, EB,
             12'o3210, 12'o2345, 12'o1543, 1, 15'h2000, '0);
    add_step("wr_zero", 1, ZERO, 15'o77777, 0, A, '0, A, ZERO,
             12'o6000, 12'o1300, 12'o0300, 1, 15'o12345, 15'o77777);
    add_step("rd_zero", 0, A, '0, 0, A, '0, ZERO, ZERO,
             12'o2400, 12'o2400, 12'o1400, 1, '0, '0);

    // Every FB value with a different EB beside it
    for (int b = 0; b < 8; b++) begin
      bank_word = {3'(b), 3'(7 - b), 9'o000};
      add_step("bank_sweep", 1, BB, bank_word, 0, A, '0, BB, ZERO,
               12'(12'o2000 + b * 12'o123), 12'(12'o1400 + b * 12'o123),
               12'(12'o1400 + b * 12'o51), 1, bank_word, '0);
    end
    add_step("bank_last", 0, A, '0, 0, A, '0, BB, ZERO,
             12'o3654, 12'o1765, 12'o1765, 1, 15'h7000, '0);
    fixed_len = steps.size();

    // Random bank words and addresses
    for (int k = 0; k < n_random; k++) begin
      seed = lcg_next(seed);
      rnd_data = seed[30:16];
      seed = lcg_next(seed);
      rnd_pc = seed[27:16];
      seed = lcg_next(seed);
      rnd_rd = seed[27:16];
      seed = lcg_next(seed);
      rnd_wr = seed[27:16];
      add_step("random", 1, BB, rnd_data, 0, A, '0, ZERO, BB,
               rnd_pc, rnd_rd, rnd_wr, seed[31], '0, rnd_data);
    end
    table_ready = 1'b1;

    repeat (reset_cycles) @(negedge clk);
    rst_l = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      run_step(i);
    end
    @(negedge clk);
    if (uut.chk.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Assertion checker reported %0d failures", uut.chk.fail_count);
      $display("** FAIL **");
      $fatal(1, "assertion failures");
    end
  end

  // Twice the expected run length
  initial begin
    longint limit;
    wait (table_ready);
    limit = longint'(fixed_len + n_random + reset_cycles) * clk_period * 2;
    #(limit);
    $display("Timeout: tests still running after %0d ns", limit);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* all.f */
logic/agc_word_pkg.sv
logic/agc_mem_pkg.sv
logic/agc_reg_file.sv
logic/rom_bank_translate.sv
logic/ram_bank_translate.sv
logic/addr_translate.sv
logic/agc_mem_unit.sv
tb/tb_clock_gen.sv
tb/agc_mem_unit_checker.sv
tb/agc_mem_unit_tb.sv

/* Makefile */
TOP = agc_mem_unit_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f all.f -Mdir obj_dir -o sim

run: build
	./obj_dir/sim +verilator+error+limit+100 | tee run.log
	grep -q "^\*\* PASS \*\*$$" run.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir run.log

.PHONY: all build run lint clean
